// File: Bender.yml
package:
  name: link_bridge

sources:
  - include_dirs:
      - include
    files:
      - rtl/link_pkg.sv
      - rtl/frame_pkg.sv
      - rtl/bit_sampler.sv
      - rtl/rx_shifter.sv
      - rtl/pkt_store.sv
      - rtl/spi_target.sv
      - rtl/tx_serializer.sv
      - rtl/link_ctrl.sv
      - rtl/link_top.sv
      - target: simulation
        files:
          - bench/link_tb.sv

// File: bench/link_tb.sv
`timescale 1ns/1ps
`include "link_defines.svh"

module link_tb import link_pkg::*; ();

    localparam int NROWS     = 8;
    localparam int RUN_LIMIT = NROWS * (64 + 8) * `LINK_BIT_DIV + 2000;
    localparam int HALF_SCK  = 4;
    // cs synchronizer, byte_done, tx_load, then the first bit on the line
    localparam int TX_LAT    = 5;

    typedef struct packed {
        link_mode_e  mode;
        logic [55:0] data;
        logic        bad_sync;
        logic        hold;
        logic [2:0]  cut;
    } row_t;

    logic clk;
    logic rst;
    logic rx;
    logic rfin;
    logic tx_hold;
    logic sck;
    logic mosi;
    logic cs;
    logic pkt_rec;
    logic miso;
    logic tx_out;

    row_t  rows [NROWS];
    string row_name [NROWS];
    string cur_name;
    int    row_errs;
    int    tests_run;
    int    tests_bad;
    int    pkt_hits = 0;
    int    cycles = 0;

    link_top u_dut (
        .clk, .rst, .rx, .rfin, .tx_hold, .sck, .mosi, .cs,
        .pkt_rec, .miso, .tx_out
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (pkt_rec) begin
            pkt_hits <= pkt_hits + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == RUN_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", RUN_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic row_t make_row(input link_mode_e mode, input logic [55:0] data,
                                      input logic bad_sync, input logic hold,
                                      input logic [2:0] cut);
        row_t r;
        r.mode     = mode;
        r.data     = data;
        r.bad_sync = bad_sync;
        r.hold     = hold;
        r.cut      = cut;
        return r;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic log_mismatch(input string what, input logic [7:0] exp,
                                input logic [7:0] got);
        $display("ERR %s %s: expected %h, got %h", cur_name, what, exp, got);
        row_errs++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", cur_name, msg);
        row_errs++;
    endtask

    task automatic end_test();
        tests_run++;
        if (row_errs != 0) begin
            tests_bad++;
            $display("%-12s %0d errors", cur_name, row_errs);
        end else begin
            $display("%-12s ok", cur_name);
        end
    endtask

    // Sync byte goes out first and every byte MSB first
    task automatic send_frame(input logic [63:0] frame);
        for (int i = 63; i >= 0; i--) begin
            rfin = frame[i];
            tick(`LINK_BIT_DIV);
        end
        rfin = 1'b0;
    endtask

    task automatic wait_pkt(input int hits0, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < `LINK_BIT_DIV && !seen; n++) begin
            if (pkt_hits != hits0) begin
                seen = 1'b1;
            end else begin
                tick(1);
            end
        end
    endtask

    // Mode 0 host that ends with cs just raised
    task automatic spi_xfer(input logic [7:0] wr, output logic [7:0] rd);
        cs   = 1'b0;
        sck  = 1'b0;
        mosi = wr[7];
        tick(6);
        for (int i = 7; i >= 0; i--) begin
            sck   = 1'b1;
            rd[i] = miso;
            tick(HALF_SCK);
            sck  = 1'b0;
            mosi = (i > 0) ? wr[i - 1] : 1'b0;
            tick(HALF_SCK);
        end
        cs = 1'b1;
    endtask

    // Mid-bit samples in LSB-first order
    task automatic watch_tx(input logic [7:0] exp);
        logic [7:0] got;
        tick(TX_LAT + `LINK_BIT_DIV / 2);
        for (int i = 0; i < 8; i++) begin
            got[i] = tx_out;
            tick(`LINK_BIT_DIV);
        end
        if (got !== exp) log_mismatch("tx_out bits", exp, got);
        if (tx_out !== 1'b1) log_mismatch("line after byte", 8'h01, {7'b0, tx_out});
    endtask

    task automatic run_row(input int r);
        row_t       t;
        logic [7:0] sync;
        logic [7:0] exp;
        logic [7:0] got;
        int         nread;
        int         hits0;
        bit         seen;
        t        = rows[r];
        cur_name = row_name[r];
        row_errs = 0;
        rx       = (t.mode == MODE_RX);
        tx_hold  = t.hold;
        tick(4);
        if (t.mode == MODE_RX) begin
            sync  = t.bad_sync ? (`LINK_SYNC_BYTE ^ 8'h01) : `LINK_SYNC_BYTE;
            hits0 = pkt_hits;
            send_frame({sync, t.data});
            if (t.bad_sync) begin
                tick(`LINK_BIT_DIV);
                spi_xfer(8'h00, got);
                tick(8);
                if (got !== 8'h00) log_mismatch("read after bad sync", 8'h00, got);
                if (pkt_hits != hits0) note_failure("pkt_rec rose for a frame with a bad sync");
            end else begin
                wait_pkt(hits0, seen);
                if (!seen) note_failure("no packet was recognized after the frame");
                nread = (t.cut != 0) ? int'(t.cut) : `LINK_PAYLOAD_BYTES;
                for (int k = 0; k < nread; k++) begin
                    // k-th byte on air after the sync byte
                    exp = t.data[8 * `LINK_PAYLOAD_BYTES - 1 - 8 * k -: 8];
                    spi_xfer(8'h00, got);
                    tick(8);
                    if (got !== exp) log_mismatch($sformatf("payload byte %0d", k), exp, got);
                end
                if (t.cut != 0) begin
                    rx = 1'b0;
                    tick(4);
                    rx = 1'b1;
                    tick(4);
                    spi_xfer(8'h00, got);
                    tick(8);
                    if (got !== 8'h00) log_mismatch("read after mode toggle", 8'h00, got);
                end
            end
        end else begin
            if (tx_out !== 1'b1) log_mismatch("line before write", 8'h01, {7'b0, tx_out});
            spi_xfer(t.data[7:0], got);
            if (tx_out !== 1'b1) log_mismatch("line at cs rise", 8'h01, {7'b0, tx_out});
            watch_tx(t.hold ? 8'hff : t.data[7:0]);
        end
        end_test();
    endtask

    initial begin
        logic [63:0] r64;
        rst       = 1'b0;
        rx        = 1'b1;
        rfin      = 1'b0;
        tx_hold   = 1'b0;
        sck       = 1'b0;
        mosi      = 1'b0;
        cs        = 1'b1;
        tests_run = 0;
        tests_bad = 0;
        void'($urandom(32'he137));

        // Bad sync row uses sparse ones so no window shifts through as a sync byte
        rows[0] = make_row(MODE_RX, 56'h0123456789abcd, 1'b0, 1'b0, 3'd0);
        row_name[0] = "rx_fixed";
        r64 = {$urandom(), $urandom()};
        rows[1] = make_row(MODE_RX, r64[55:0], 1'b0, 1'b0, 3'd0);
        row_name[1] = "rx_random";
        rows[2] = make_row(MODE_RX, 56'h11111111111111, 1'b1, 1'b0, 3'd0);
        row_name[2] = "rx_bad_sync";
        rows[3] = make_row(MODE_TX, 56'h96, 1'b0, 1'b0, 3'd0);
        row_name[3] = "tx_fixed";
        r64 = {$urandom(), $urandom()};
        rows[4] = make_row(MODE_TX, {48'h0, r64[7:0]}, 1'b0, 1'b0, 3'd0);
        row_name[4] = "tx_random";
        rows[5] = make_row(MODE_TX, 56'h3c, 1'b0, 1'b1, 3'd0);
        row_name[5] = "tx_hold";
        r64 = {$urandom(), $urandom()};
        rows[6] = make_row(MODE_RX, r64[55:0], 1'b0, 1'b0, 3'd3);
        row_name[6] = "rx_abort";
        r64 = {$urandom(), $urandom()};
        rows[7] = make_row(MODE_RX, r64[55:0], 1'b0, 1'b0, 3'd0);
        row_name[7] = "rx_recover";

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        tick(2);

        cur_name = "reset_state";
        row_errs = 0;
        if (pkt_rec !== 1'b0) log_mismatch("pkt_rec", 8'h00, {7'b0, pkt_rec});
        if (miso !== 1'b0) log_mismatch("miso", 8'h00, {7'b0, miso});
        if (tx_out !== 1'b1) log_mismatch("tx_out", 8'h01, {7'b0, tx_out});
        end_test();

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        $display("Summary: %0d tests run, %0d with errors", tests_run, tests_bad);
        if (tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: include/link_defines.svh
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// Clock cycles per radio bit, keep at 8 or more
`define LINK_BIT_DIV 16

// First byte on air of every radio frame
`define LINK_SYNC_BYTE 8'hA5

// Payload bytes following the sync byte
`define LINK_PAYLOAD_BYTES 7

`endif

// File: rtl/bit_sampler.sv
`timescale 1ns/1ps
`include "link_defines.svh"

module bit_sampler (
    input  logic clk,
    input  logic rst,
    input  logic rfin,
    output logic din,
    output logic sh_en
);

    localparam int CW = $clog2(`LINK_BIT_DIV);

    logic [1:0]    sync_q;
    logic          din_q;
    logic          edge_det;
    logic [CW-1:0] phase;

    assign din      = sync_q[1];
    assign edge_det = din ^ din_q;
    // Tick half a bit after the last transition
    assign sh_en    = (phase == CW'(`LINK_BIT_DIV / 2));

    always_ff @(posedge clk) begin
        if (!rst) begin
            sync_q <= '0;
            din_q  <= 1'b0;
            phase  <= '0;
        end else begin
            sync_q <= {sync_q[0], rfin};
            din_q  <= din;
            if (edge_det) begin
                phase <= CW'(1);
            end else if (phase == CW'(`LINK_BIT_DIV - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (!rst) sh_en |=> !sh_en);

endmodule

// File: rtl/frame_pkg.sv
package frame_pkg;

    // One byte as moved over SPI
    typedef logic [7:0] spi_byte_t;

    // Radio frame, sync goes out first, then payload byte 0 in the top bits
    typedef struct packed {
        spi_byte_t   sync;
        logic [55:0] payload;
    } rf_frame_t;

endpackage

// File: rtl/link_ctrl.sv
`timescale 1ns/1ps
`include "link_defines.svh"

module link_ctrl import link_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  link_mode_e   mode,
    input  logic         pkt_rec,
    input  logic         last,
    input  logic         byte_done,
    input  logic         tx_done,
    output ctrl_strobe_t strobe
);

    localparam logic [2:0] LAST_CNT = 3'(`LINK_PAYLOAD_BYTES - 1);

    rx_state_e  rx_state;
    tx_state_e  tx_state;
    link_mode_e mode_q;
    logic       pkt_rec_q;
    logic [2:0] rd_cnt;
    logic       mode_chg;

    assign mode_chg = (mode != mode_q);

    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_state  <= RX_HUNT;
            tx_state  <= TX_IDLE;
            mode_q    <= mode;
            pkt_rec_q <= 1'b0;
            rd_cnt    <= '0;
            strobe    <= '0;
        end else begin
            mode_q          <= mode;
            pkt_rec_q       <= pkt_rec;
            strobe.pkt_load <= 1'b0;
            strobe.pkt_next <= 1'b0;
            strobe.rx_clear <= 1'b0;
            strobe.tx_load  <= 1'b0;
            if (mode_chg) begin
                // Drop whatever was in flight
                rx_state        <= RX_HUNT;
                tx_state        <= TX_IDLE;
                rd_cnt          <= '0;
                strobe.rx_clear <= 1'b1;
                strobe.tx_run   <= 1'b0;
            end else if (mode == MODE_RX) begin
                case (rx_state)
                    RX_HUNT: begin
                        rd_cnt <= '0;
                        if (pkt_rec && !pkt_rec_q) begin
                            strobe.pkt_load <= 1'b1;
                            strobe.rx_clear <= 1'b1;
                            rx_state        <= RX_STORE;
                        end
                    end
                    RX_STORE: begin
                        rx_state <= RX_WAIT_CS;
                    end
                    RX_WAIT_CS: begin
                        if (byte_done) begin
                            strobe.pkt_next <= 1'b1;
                            rx_state        <= RX_XFER;
                        end
                    end
                    RX_XFER: begin
                        if (rd_cnt == LAST_CNT) begin
                            rx_state <= RX_HUNT;
                        end else begin
                            rd_cnt   <= rd_cnt + 3'd1;
                            rx_state <= RX_WAIT_CS;
                        end
                    end
                    default: rx_state <= RX_HUNT;
                endcase
            end else begin
                case (tx_state)
                    TX_IDLE: begin
                        if (byte_done) begin
                            strobe.tx_load <= 1'b1;
                            strobe.tx_run  <= 1'b1;
                            tx_state       <= TX_SEND;
                        end
                    end
                    TX_SEND: begin
                        tx_state <= TX_WAIT_END;
                    end
                    TX_WAIT_END: begin
                        if (tx_done) begin
                            strobe.tx_run <= 1'b0;
                            tx_state      <= TX_IDLE;
                        end
                    end
                    default: tx_state <= TX_IDLE;
                endcase
            end
        end
    end

    a_load_excl: assert property (@(posedge clk) disable iff (!rst)
        !(strobe.pkt_load && strobe.tx_load));

    a_reset_quiet: assert property (@(posedge clk) !rst |=> strobe == '0);

    // Read count and store index must agree on the final byte
    a_last_match: assert property (@(posedge clk) disable iff (!rst)
        rx_state == RX_XFER |-> last == (rd_cnt == LAST_CNT));

endmodule

// File: rtl/link_pkg.sv
package link_pkg;

    // Level of the rx input
    typedef enum logic {
        MODE_TX = 1'b0,
        MODE_RX = 1'b1
    } link_mode_e;

    typedef enum logic [2:0] {
        RX_HUNT    = 3'd0,
        RX_STORE   = 3'd1,
        RX_WAIT_CS = 3'd2,
        RX_XFER    = 3'd3
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE     = 2'd0,
        TX_WAIT_END = 2'd1,
        TX_SEND     = 2'd2
    } tx_state_e;

    // Single-cycle pulses, except tx_run
    typedef struct packed {
        logic pkt_load;
        logic pkt_next;
        logic rx_clear;
        logic tx_load;
        logic tx_run;
    } ctrl_strobe_t;

endpackage

// File: rtl/link_top.sv
`timescale 1ns/1ps

module link_top import link_pkg::*, frame_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    input  logic rfin,
    input  logic tx_hold,
    input  logic sck,
    input  logic mosi,
    input  logic cs,
    output logic pkt_rec,
    output logic miso,
    output logic tx_out
);

    link_mode_e   mode;
    ctrl_strobe_t strobe;
    rf_frame_t    frame;
    spi_byte_t    cur_byte;
    spi_byte_t    rx_byte;
    logic         din;
    logic         sh_en;
    logic         last;
    logic         byte_done;
    logic         tx_line;
    logic         tx_done;

    assign mode   = link_mode_e'(rx);
    // Hold forces the line to idle
    assign tx_out = tx_hold | tx_line;

    bit_sampler u_bit_sampler (.clk, .rst, .rfin, .din, .sh_en);

    rx_shifter u_rx_shifter (.clk, .rst, .din, .sh_en, .mode, .strobe, .frame, .pkt_rec);

    pkt_store u_pkt_store (.clk, .rst, .frame, .strobe, .cur_byte, .last);

    spi_target u_spi_target (
        .clk, .rst, .sck, .mosi, .cs,
        .tx_byte(cur_byte), .miso, .rx_byte, .byte_done
    );

    tx_serializer u_tx_serializer (
        .clk, .rst, .load(strobe.tx_load), .din(rx_byte), .line(tx_line), .done(tx_done)
    );

    link_ctrl u_link_ctrl (.clk, .rst, .mode, .pkt_rec, .last, .byte_done, .tx_done, .strobe);

endmodule

// File: rtl/pkt_store.sv
`timescale 1ns/1ps
`include "link_defines.svh"

module pkt_store import link_pkg::*, frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  rf_frame_t    frame,
    input  ctrl_strobe_t strobe,
    output spi_byte_t    cur_byte,
    output logic         last
);

    localparam logic [2:0] END_IDX = 3'(`LINK_PAYLOAD_BYTES);

    spi_byte_t  bytes_q [`LINK_PAYLOAD_BYTES];
    logic [2:0] idx;

    // Past the end reads as zero
    assign cur_byte = (idx < END_IDX) ? bytes_q[idx] : '0;
    assign last     = (idx == END_IDX - 3'd1);

    always_ff @(posedge clk) begin
        if (strobe.pkt_load) begin
            for (int i = 0; i < `LINK_PAYLOAD_BYTES; i++) begin
                bytes_q[i] <= frame.payload[8 * (`LINK_PAYLOAD_BYTES - 1 - i) +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            idx <= END_IDX;
        end else if (strobe.pkt_load) begin
            idx <= '0;
        end else if (strobe.rx_clear) begin
            idx <= END_IDX;
        end else if (strobe.pkt_next && idx != END_IDX) begin
            idx <= idx + 3'd1;
        end
    end

    a_no_overread: assert property (@(posedge clk) disable iff (!rst)
        strobe.pkt_next |-> idx != END_IDX);

endmodule

// File: rtl/rx_shifter.sv
`timescale 1ns/1ps
`include "link_defines.svh"

module rx_shifter import link_pkg::*, frame_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         din,
    input  logic         sh_en,
    input  link_mode_e   mode,
    input  ctrl_strobe_t strobe,
    output rf_frame_t    frame,
    output logic         pkt_rec
);

    // Oldest byte sits in the sync field
    assign pkt_rec = (frame.sync == `LINK_SYNC_BYTE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            frame <= '0;
        end else if (strobe.rx_clear) begin
            frame <= '0;
        end else if (sh_en && mode == MODE_RX) begin
            frame <= rf_frame_t'({frame[62:0], din});
        end
    end

endmodule

// File: rtl/spi_target.sv
`timescale 1ns/1ps

module spi_target import frame_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sck,
    input  logic      mosi,
    input  logic      cs,
    input  spi_byte_t tx_byte,
    output logic      miso,
    output spi_byte_t rx_byte,
    output logic      byte_done
);

    logic [2:0] sck_r;
    logic [2:0] cs_r;
    logic [1:0] mosi_r;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_rise;
    logic       cs_fall;
    logic       active;
    logic [3:0] bit_cnt;
    spi_byte_t  rx_sh;
    spi_byte_t  tx_sh;

    // Bit 2 of each chain is the previous synchronized value
    assign sck_rise = sck_r[1] & ~sck_r[2];
    assign sck_fall = ~sck_r[1] & sck_r[2];
    assign cs_rise  = cs_r[1] & ~cs_r[2];
    assign cs_fall  = ~cs_r[1] & cs_r[2];
    assign active   = ~cs_r[1];

    // Delayed cs so the captured byte is in place first
    assign miso = ~cs_r[2] & tx_sh[7];

    always_ff @(posedge clk) begin
        if (!rst) begin
            sck_r     <= '0;
            cs_r      <= '1;
            mosi_r    <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            sck_r     <= {sck_r[1:0], sck};
            cs_r      <= {cs_r[1:0], cs};
            mosi_r    <= {mosi_r[0], mosi};
            byte_done <= cs_rise & bit_cnt[3];
            if (cs_fall) begin
                bit_cnt <= '0;
            end else if (sck_rise && active && !bit_cnt[3]) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_fall) begin
            tx_sh <= tx_byte;
        end else if (sck_fall && active) begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
        if (sck_rise && active) begin
            rx_sh <= {rx_sh[6:0], mosi_r[1]};
        end
        if (cs_rise && bit_cnt[3]) begin
            rx_byte <= rx_sh;
        end
    end

endmodule

// File: rtl/tx_serializer.sv
`timescale 1ns/1ps
`include "link_defines.svh"

module tx_serializer import frame_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  spi_byte_t din,
    output logic      line,
    output logic      done
);

    localparam int TW = $clog2(`LINK_BIT_DIV);

    spi_byte_t     shreg;
    logic [TW-1:0] timer;
    logic [2:0]    bit_cnt;
    logic          busy;
    logic          bit_end;

    assign bit_end = busy && (timer == '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            line    <= 1'b1;
            done    <= 1'b0;
            busy    <= 1'b0;
            timer   <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                // Bit 0 goes out right away
                line    <= din[0];
                busy    <= 1'b1;
                timer   <= TW'(`LINK_BIT_DIV - 1);
                bit_cnt <= '0;
            end else if (bit_end) begin
                timer   <= TW'(`LINK_BIT_DIV - 1);
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    line <= 1'b1;
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    line <= shreg[0];
                end
            end else if (busy) begin
                timer <= timer - 1'b1;
            end
        end
    end

    // Ones fill in from the top
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {1'b1, din[7:1]};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[7:1]};
        end
    end

endmodule

// File: sim.f
+incdir+include
rtl/link_pkg.sv
rtl/frame_pkg.sv
rtl/bit_sampler.sv
rtl/rx_shifter.sv
rtl/pkt_store.sv
rtl/spi_target.sv
rtl/tx_serializer.sv
rtl/link_ctrl.sv
rtl/link_top.sv
bench/link_tb.sv
